// File: logic/cache_pkg.sv
// widths, address fields, cache entry types and controller states for both caches
package cache_pkg;

	// ----------------------------------------------------------------------
	// sizes
	// ----------------------------------------------------------------------
	localparam int WORD_W         = 32;
	localparam int LINE_W         = 128;                   // also the memory bus width
	localparam int WORDS_PER_LINE = LINE_W / WORD_W;
	localparam int N_SETS         = 4;
	localparam int PROC_ADDR_W    = 30;                    // word address
	localparam int MEM_ADDR_W     = PROC_ADDR_W - $clog2(WORDS_PER_LINE);
	localparam int TAG_W          = MEM_ADDR_W - $clog2(N_SETS);

	typedef logic [WORD_W-1:0]                 word_t;
	typedef logic [LINE_W-1:0]                 line_t;
	typedef logic [TAG_W-1:0]                  tag_t;
	typedef logic [$clog2(N_SETS)-1:0]         index_t;
	typedef logic [$clog2(WORDS_PER_LINE)-1:0] offset_t;

	// ----------------------------------------------------------------------
	// addresses
	// ----------------------------------------------------------------------
	// processor word address, msb first
	typedef struct packed {
		tag_t    tag;
		index_t  index;
		offset_t offset;
	} proc_addr_t;

	// line address on the slow memory port
	typedef struct packed {
		tag_t   tag;
		index_t index;
	} mem_addr_t;

	// ----------------------------------------------------------------------
	// line store entries
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic  valid;
		logic  dirty;    // line differs from memory
		tag_t  tag;
		line_t line;
	} dline_t;

	typedef struct packed {
		logic  valid;
		tag_t  tag;
		line_t line;
	} iline_t;

	// ----------------------------------------------------------------------
	// controller states
	// ----------------------------------------------------------------------
	typedef enum logic [1:0] {
		DC_COMPARE_TAG = 2'b00,
		DC_WRITE_BACK  = 2'b01,
		DC_ALLOCATE    = 2'b10
	} dstate_t;

	typedef enum logic {
		IC_COMPARE_TAG = 1'b0,
		IC_ALLOCATE    = 1'b1
	} istate_t;

endpackage

// File: logic/cache_subsystem.sv
// top level with the data cache, the instruction cache and their line stores
`timescale 1ns/100ps

module cache_subsystem #(
	parameter int n_sets = cache_pkg::N_SETS
) (
	input  logic                  clk,
	input  logic                  proc_reset,
	// data cache, processor side
	input  logic                  d_proc_read,
	input  logic                  d_proc_write,
	input  cache_pkg::proc_addr_t d_proc_addr,
	input  cache_pkg::word_t      d_proc_wdata,
	output cache_pkg::word_t      d_proc_rdata,
	output logic                  d_proc_stall,
	// data cache, memory side
	output logic                  d_mem_read,
	output logic                  d_mem_write,
	output cache_pkg::mem_addr_t  d_mem_addr,
	output cache_pkg::line_t      d_mem_wdata,
	input  cache_pkg::line_t      d_mem_rdata,
	input  logic                  d_mem_ready,
	// instruction cache, processor side
	input  logic                  i_proc_read,
	input  cache_pkg::proc_addr_t i_proc_addr,
	output cache_pkg::word_t      i_proc_rdata,
	output logic                  i_proc_stall,
	// instruction cache, memory side
	output logic                  i_mem_read,
	output cache_pkg::mem_addr_t  i_mem_addr,
	input  cache_pkg::line_t      i_mem_rdata,
	input  logic                  i_mem_ready
);

	// ----------------------------------------------------------------------
	// data cache
	// ----------------------------------------------------------------------
	cache_pkg::index_t d_index;
	cache_pkg::dline_t d_way0_q;
	cache_pkg::dline_t d_way1_q;
	cache_pkg::dline_t d_wr_entry;
	logic              d_repl_way;
	logic              d_wr_en0;
	logic              d_wr_en1;
	logic              d_fill;

	dcache_ctrl u_dcache_ctrl (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (d_proc_read),
		.proc_write (d_proc_write),
		.proc_addr  (d_proc_addr),
		.proc_wdata (d_proc_wdata),
		.proc_rdata (d_proc_rdata),
		.proc_stall (d_proc_stall),
		.mem_read   (d_mem_read),
		.mem_write  (d_mem_write),
		.mem_addr   (d_mem_addr),
		.mem_wdata  (d_mem_wdata),
		.mem_rdata  (d_mem_rdata),
		.mem_ready  (d_mem_ready),
		.index      (d_index),
		.way0_q     (d_way0_q),
		.way1_q     (d_way1_q),
		.repl_way   (d_repl_way),
		.wr_en0     (d_wr_en0),
		.wr_en1     (d_wr_en1),
		.wr_entry   (d_wr_entry),
		.fill       (d_fill)
	);

	line_store #(
		.entry_t (cache_pkg::dline_t),
		.n_sets  (n_sets)
	) u_dstore (
		.clk        (clk),
		.proc_reset (proc_reset),
		.index      (d_index),
		.way0_q     (d_way0_q),
		.way1_q     (d_way1_q),
		.repl_way   (d_repl_way),
		.wr_en0     (d_wr_en0),
		.wr_en1     (d_wr_en1),
		.wr_entry   (d_wr_entry),
		.fill       (d_fill)
	);

	// ----------------------------------------------------------------------
	// instruction cache
	// ----------------------------------------------------------------------
	cache_pkg::index_t i_index;
	cache_pkg::iline_t i_way0_q;
	cache_pkg::iline_t i_way1_q;
	cache_pkg::iline_t i_wr_entry;
	logic              i_repl_way;
	logic              i_wr_en0;
	logic              i_wr_en1;
	logic              i_fill;

	icache_ctrl u_icache_ctrl (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (i_proc_read),
		.proc_addr  (i_proc_addr),
		.proc_rdata (i_proc_rdata),
		.proc_stall (i_proc_stall),
		.mem_read   (i_mem_read),
		.mem_addr   (i_mem_addr),
		.mem_rdata  (i_mem_rdata),
		.mem_ready  (i_mem_ready),
		.index      (i_index),
		.way0_q     (i_way0_q),
		.way1_q     (i_way1_q),
		.repl_way   (i_repl_way),
		.wr_en0     (i_wr_en0),
		.wr_en1     (i_wr_en1),
		.wr_entry   (i_wr_entry),
		.fill       (i_fill)
	);

	line_store #(
		.entry_t (cache_pkg::iline_t),
		.n_sets  (n_sets)
	) u_istore (
		.clk        (clk),
		.proc_reset (proc_reset),
		.index      (i_index),
		.way0_q     (i_way0_q),
		.way1_q     (i_way1_q),
		.repl_way   (i_repl_way),
		.wr_en0     (i_wr_en0),
		.wr_en1     (i_wr_en1),
		.wr_entry   (i_wr_entry),
		.fill       (i_fill)
	);

endmodule

// File: logic/dcache_ctrl.sv
// write-back data cache controller with tag compare, write-back and allocate states
`timescale 1ns/100ps

module dcache_ctrl (
	input  logic                  clk,
	input  logic                  proc_reset,
	// processor port
	input  logic                  proc_read,
	input  logic                  proc_write,
	input  cache_pkg::proc_addr_t proc_addr,
	input  cache_pkg::word_t      proc_wdata,
	output cache_pkg::word_t      proc_rdata,
	output logic                  proc_stall,
	// slow memory port
	output logic                  mem_read,
	output logic                  mem_write,
	output cache_pkg::mem_addr_t  mem_addr,
	output cache_pkg::line_t      mem_wdata,
	input  cache_pkg::line_t      mem_rdata,
	input  logic                  mem_ready,
	// line store
	output cache_pkg::index_t     index,
	input  cache_pkg::dline_t     way0_q,
	input  cache_pkg::dline_t     way1_q,
	input  logic                  repl_way,
	output logic                  wr_en0,
	output logic                  wr_en1,
	output cache_pkg::dline_t     wr_entry,
	output logic                  fill
);

	cache_pkg::dstate_t   state;
	cache_pkg::dstate_t   state_nxt;
	logic                 hit0;
	logic                 hit1;
	logic                 hit;
	logic                 miss;
	cache_pkg::dline_t    hit_entry;
	cache_pkg::dline_t    victim;
	cache_pkg::dline_t    merged;     // hit line with the write word in place
	cache_pkg::dline_t    refill;
	cache_pkg::mem_addr_t refill_addr;
	cache_pkg::mem_addr_t victim_addr;

	// ----------------------------------------------------------------------
	// tag compare
	// ----------------------------------------------------------------------
	assign index = proc_addr.index;   // processor holds it for the whole miss

	assign hit0 = way0_q.valid && (way0_q.tag == proc_addr.tag);
	assign hit1 = way1_q.valid && (way1_q.tag == proc_addr.tag);
	assign hit  = hit0 || hit1;
	assign miss = (proc_read || proc_write) && !hit;

	assign hit_entry = hit0 ? way0_q : way1_q;
	assign victim    = repl_way ? way1_q : way0_q;

	// offset word of the hitting way
	assign proc_rdata =
		hit_entry.line[proc_addr.offset * cache_pkg::WORD_W +: cache_pkg::WORD_W];

	always_comb begin
		merged = hit_entry;
		merged.dirty = 1'b1;
		merged.line[proc_addr.offset * cache_pkg::WORD_W +: cache_pkg::WORD_W] = proc_wdata;
	end

	// refilled line comes in clean
	assign refill = '{valid: 1'b1, dirty: 1'b0, tag: proc_addr.tag, line: mem_rdata};

	assign refill_addr = '{tag: proc_addr.tag, index: proc_addr.index};
	assign victim_addr = '{tag: victim.tag, index: proc_addr.index};

	// ----------------------------------------------------------------------
	// FSM
	// ----------------------------------------------------------------------
	always_comb begin
		state_nxt  = state;
		proc_stall = 1'b1;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		mem_addr   = refill_addr;
		mem_wdata  = victim.line;
		wr_en0     = 1'b0;
		wr_en1     = 1'b0;
		wr_entry   = merged;
		fill       = 1'b0;

		case (state)
			cache_pkg::DC_COMPARE_TAG: begin
				proc_stall = miss;
				if (proc_write && hit) begin
					wr_en0 = hit0;          // way 0 wins a double match
					wr_en1 = !hit0;
				end
				if (miss) begin
					// victim is always the replacement way
					if (victim.valid && victim.dirty) begin
						state_nxt = cache_pkg::DC_WRITE_BACK;
					end else begin
						state_nxt = cache_pkg::DC_ALLOCATE;
					end
				end
			end

			cache_pkg::DC_WRITE_BACK: begin
				mem_write = 1'b1;
				mem_addr  = victim_addr;
				if (mem_ready) begin
					state_nxt = cache_pkg::DC_ALLOCATE;
				end
			end

			cache_pkg::DC_ALLOCATE: begin
				mem_read = 1'b1;
				wr_entry = refill;
				if (mem_ready) begin
					wr_en0    = !repl_way;
					wr_en1    = repl_way;
					fill      = 1'b1;
					state_nxt = cache_pkg::DC_COMPARE_TAG;   // access retries as a hit
				end
			end

			default: begin
				state_nxt = cache_pkg::DC_COMPARE_TAG;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= cache_pkg::DC_COMPARE_TAG;
		end else begin
			state <= state_nxt;
		end
	end

endmodule

// File: logic/icache_ctrl.sv
// read-only instruction cache controller with tag compare and allocate states
`timescale 1ns/100ps

module icache_ctrl (
	input  logic                  clk,
	input  logic                  proc_reset,
	// fetch port
	input  logic                  proc_read,
	input  cache_pkg::proc_addr_t proc_addr,
	output cache_pkg::word_t      proc_rdata,
	output logic                  proc_stall,
	// slow memory port, reads only
	output logic                  mem_read,
	output cache_pkg::mem_addr_t  mem_addr,
	input  cache_pkg::line_t      mem_rdata,
	input  logic                  mem_ready,
	// line store
	output cache_pkg::index_t     index,
	input  cache_pkg::iline_t     way0_q,
	input  cache_pkg::iline_t     way1_q,
	input  logic                  repl_way,
	output logic                  wr_en0,
	output logic                  wr_en1,
	output cache_pkg::iline_t     wr_entry,
	output logic                  fill
);

	cache_pkg::istate_t state;
	cache_pkg::istate_t state_nxt;
	logic               hit0;
	logic               hit1;
	logic               miss;
	cache_pkg::iline_t  hit_entry;

	assign index = proc_addr.index;

	// ----------------------------------------------------------------------
	// tag compare
	// ----------------------------------------------------------------------
	assign hit0 = way0_q.valid && (way0_q.tag == proc_addr.tag);
	assign hit1 = way1_q.valid && (way1_q.tag == proc_addr.tag);
	assign miss = proc_read && !(hit0 || hit1);

	assign hit_entry  = hit0 ? way0_q : way1_q;
	assign proc_rdata =
		hit_entry.line[proc_addr.offset * cache_pkg::WORD_W +: cache_pkg::WORD_W];

	// refill always goes to the replacement way
	assign mem_addr = '{tag: proc_addr.tag, index: proc_addr.index};
	assign wr_entry = '{valid: 1'b1, tag: proc_addr.tag, line: mem_rdata};

	// ----------------------------------------------------------------------
	// FSM
	// ----------------------------------------------------------------------
	always_comb begin
		state_nxt  = state;
		proc_stall = 1'b1;
		mem_read   = 1'b0;
		wr_en0     = 1'b0;
		wr_en1     = 1'b0;
		fill       = 1'b0;

		case (state)
			cache_pkg::IC_COMPARE_TAG: begin
				proc_stall = miss;
				if (miss) begin
					state_nxt = cache_pkg::IC_ALLOCATE;
				end
			end

			cache_pkg::IC_ALLOCATE: begin
				mem_read = 1'b1;     // held through the ready cycle
				if (mem_ready) begin
					wr_en0    = !repl_way;
					wr_en1    = repl_way;
					fill      = 1'b1;
					state_nxt = cache_pkg::IC_COMPARE_TAG;
				end
			end

			default: begin
				state_nxt = cache_pkg::IC_COMPARE_TAG;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= cache_pkg::IC_COMPARE_TAG;
		end else begin
			state <= state_nxt;
		end
	end

endmodule

// File: logic/line_store.sv
// two-way line storage with a per-set replacement bit, generic over the entry type
`timescale 1ns/100ps

module line_store #(
	parameter type entry_t = cache_pkg::dline_t,
	parameter int  n_sets  = cache_pkg::N_SETS
) (
	input  logic              clk,
	input  logic              proc_reset,
	input  cache_pkg::index_t index,
	// read side, both ways of the set
	output entry_t            way0_q,
	output entry_t            way1_q,
	output logic              repl_way,   // next victim of the set
	// write side
	input  logic              wr_en0,
	input  logic              wr_en1,
	input  entry_t            wr_entry,
	input  logic              fill        // write is a refill from memory
);

	// ----------------------------------------------------------------------
	// storage
	// ----------------------------------------------------------------------
	entry_t            way0 [n_sets];
	entry_t            way1 [n_sets];
	logic [n_sets-1:0] repl;          // 0 = way 0 goes next

	// combinational read of the indexed set
	assign way0_q   = way0[index];
	assign way1_q   = way1[index];
	assign repl_way = repl[index];

	// ----------------------------------------------------------------------
	// update
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			for (int s = 0; s < n_sets; s++) begin
				way0[s] <= '0;   // all entries invalid
				way1[s] <= '0;
			end
			repl <= '0;
		end else begin
			if (wr_en0) begin
				way0[index] <= wr_entry;
			end
			if (wr_en1) begin
				way1[index] <= wr_entry;
			end
			// fill order, the way just filled becomes the newest
			if (fill) begin
				repl[index] <= wr_en0;
			end
		end
	end

endmodule

// File: sim.f
logic/cache_pkg.sv
logic/line_store.sv
logic/dcache_ctrl.sv
logic/icache_ctrl.sv
logic/cache_subsystem.sv
verification/slow_mem.sv
verification/cache_tb.sv

// File: verification/cache_tb.sv
// testbench with clock, reset, directed and random stimulus, reference model and checks
`timescale 1ns/100ps

module cache_tb;

	localparam int               MEM_LATENCY    = 3;
	localparam int               SEED           = 76;
	localparam int               N_RANDOM       = 300;
	localparam int               N_DIRECTED     = 20;
	localparam int               ACCESS_COUNT   = N_DIRECTED + N_RANDOM;
	localparam int               TIMEOUT_CYCLES = ACCESS_COUNT * (2 * MEM_LATENCY + 6) + 100;
	localparam int               MEM_LINES      = 64;
	localparam int               SHADOW_WORDS   = MEM_LINES * cache_pkg::WORDS_PER_LINE;
	localparam cache_pkg::word_t D_PATTERN      = 32'h5a5a_0000;
	localparam cache_pkg::word_t I_PATTERN      = 32'h1357_0000;

	logic                  clk;
	logic                  proc_reset;
	logic                  d_proc_read;
	logic                  d_proc_write;
	cache_pkg::proc_addr_t d_proc_addr;
	cache_pkg::word_t      d_proc_wdata;
	cache_pkg::word_t      d_proc_rdata;
	logic                  d_proc_stall;
	logic                  d_mem_read;
	logic                  d_mem_write;
	cache_pkg::mem_addr_t  d_mem_addr;
	cache_pkg::line_t      d_mem_wdata;
	cache_pkg::line_t      d_mem_rdata;
	logic                  d_mem_ready;
	logic                  i_proc_read;
	cache_pkg::proc_addr_t i_proc_addr;
	cache_pkg::word_t      i_proc_rdata;
	logic                  i_proc_stall;
	logic                  i_mem_read;
	cache_pkg::mem_addr_t  i_mem_addr;
	cache_pkg::line_t      i_mem_rdata;
	logic                  i_mem_ready;

	cache_pkg::word_t      shadow [SHADOW_WORDS];    // data memory as the processor sees it
	cache_pkg::mem_addr_t  last_wb_addr;
	int                    value_errors = 0;
	int                    other_errors = 0;
	int                    wb_count     = 0;
	int                    d_mem_cycles = 0;
	int                    i_mem_cycles = 0;
	int                    cycle_count  = 0;

	cache_subsystem #(.n_sets(cache_pkg::N_SETS)) u_cache_subsystem (.*);

	slow_mem #(.mem_latency(MEM_LATENCY), .n_lines(MEM_LINES), .pattern(D_PATTERN)) u_dmem (
		.clk(clk), .proc_reset(proc_reset),
		.mem_read(d_mem_read), .mem_write(d_mem_write), .mem_addr(d_mem_addr),
		.mem_wdata(d_mem_wdata), .mem_rdata(d_mem_rdata), .mem_ready(d_mem_ready)
	);

	// instruction side never writes
	slow_mem #(.mem_latency(MEM_LATENCY), .n_lines(MEM_LINES), .pattern(I_PATTERN)) u_imem (
		.clk(clk), .proc_reset(proc_reset),
		.mem_read(i_mem_read), .mem_write(1'b0), .mem_addr(i_mem_addr),
		.mem_wdata('0), .mem_rdata(i_mem_rdata), .mem_ready(i_mem_ready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------
	function automatic cache_pkg::word_t init_word(input cache_pkg::word_t pat,
		input int unsigned word_addr);
		return cache_pkg::word_t'(word_addr) ^ pat;
	endfunction

	function automatic cache_pkg::proc_addr_t make_addr(input int unsigned tag,
		input int unsigned index, input int unsigned offset);
		cache_pkg::proc_addr_t a;
		a.tag    = cache_pkg::tag_t'(tag);
		a.index  = cache_pkg::index_t'(index);
		a.offset = cache_pkg::offset_t'(offset);
		return a;
	endfunction

	function automatic cache_pkg::mem_addr_t line_of(input cache_pkg::proc_addr_t addr);
		cache_pkg::mem_addr_t m;
		m.tag   = addr.tag;
		m.index = addr.index;
		return m;
	endfunction

	function automatic int unsigned shadow_slot(input cache_pkg::proc_addr_t addr);
		logic [cache_pkg::PROC_ADDR_W-1:0] a;
		a = addr;
		return a % SHADOW_WORDS;
	endfunction

	function automatic cache_pkg::word_t ref_word(input cache_pkg::proc_addr_t addr);
		return shadow[shadow_slot(addr)];
	endfunction

	function automatic cache_pkg::word_t ref_iword(input cache_pkg::proc_addr_t addr);
		logic [cache_pkg::PROC_ADDR_W-1:0] a;
		a = addr;
		return init_word(I_PATTERN, a);
	endfunction

	// offset 0 sits in the low word of a line
	function automatic cache_pkg::line_t ref_line(input cache_pkg::mem_addr_t ma);
		cache_pkg::line_t l;
		for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
			l[w*cache_pkg::WORD_W +: cache_pkg::WORD_W] = ref_word(make_addr(ma.tag, ma.index, w));
		end
		return l;
	endfunction

	initial begin
		for (int i = 0; i < SHADOW_WORDS; i++) begin
			shadow[i] = init_word(D_PATTERN, i);
		end
	end

	// ----------------------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------------------
	task automatic check_word(input string name, input cache_pkg::word_t got,
		input cache_pkg::word_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_line(input string name, input cache_pkg::line_t got,
		input cache_pkg::line_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_mem_addr(input string name, input cache_pkg::mem_addr_t got,
		input cache_pkg::mem_addr_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic flag_error(input string msg);
		other_errors++;
		$display("ERROR %s at %0t", msg, $time);
	endtask

	// ----------------------------------------------------------------------
	// compare process sampled mid-cycle
	// ----------------------------------------------------------------------
	always @(negedge clk) begin
		if (!proc_reset) begin
			if (d_proc_read && !d_proc_stall) begin
				check_word("d_proc_rdata", d_proc_rdata, ref_word(d_proc_addr));
			end
			if (d_proc_write && !d_proc_stall) begin
				shadow[shadow_slot(d_proc_addr)] = d_proc_wdata;
			end
			if (i_proc_read && !i_proc_stall) begin
				check_word("i_proc_rdata", i_proc_rdata, ref_iword(i_proc_addr));
			end
			if (d_mem_read && d_mem_write) begin
				flag_error("data memory read and write requested together");
			end
			if (d_proc_stall && !(d_proc_read || d_proc_write)) begin
				flag_error("data cache stalls with no access pending");
			end
			if (i_proc_stall && !i_proc_read) begin
				flag_error("instruction cache stalls with no access pending");
			end
			if (d_mem_read && d_mem_ready) begin
				check_mem_addr("d_mem_addr", d_mem_addr, line_of(d_proc_addr));
			end
			if (d_mem_write && d_mem_ready) begin   // write-back must carry the shadow line
				check_line("d_mem_wdata", d_mem_wdata, ref_line(d_mem_addr));
				last_wb_addr = d_mem_addr;
				wb_count++;
			end
			if (i_mem_read && i_mem_ready) begin
				check_mem_addr("i_mem_addr", i_mem_addr, line_of(i_proc_addr));
			end
			if (d_mem_read || d_mem_write) d_mem_cycles++;
			if (i_mem_read) i_mem_cycles++;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("ERROR run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("errors: %0d value, %0d other", value_errors, other_errors + 1);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// processor side drivers entered 2 ns after a rising edge
	// ----------------------------------------------------------------------
	task automatic d_access(input logic wr, input cache_pkg::proc_addr_t addr,
		input cache_pkg::word_t wdata, output int waits, output cache_pkg::word_t rdata);
		waits        = 0;
		d_proc_read  = !wr;
		d_proc_write = wr;
		d_proc_addr  = addr;
		d_proc_wdata = wdata;
		@(negedge clk);
		while (d_proc_stall) begin
			waits++;
			@(negedge clk);
		end
		rdata = d_proc_rdata;
		@(posedge clk);
		#2;
		d_proc_read  = 1'b0;
		d_proc_write = 1'b0;
	endtask

	task automatic i_read(input cache_pkg::proc_addr_t addr, output int waits);
		waits       = 0;
		i_proc_read = 1'b1;
		i_proc_addr = addr;
		@(negedge clk);
		while (i_proc_stall) begin
			waits++;
			@(negedge clk);
		end
		@(posedge clk);
		#2;
		i_proc_read = 1'b0;
	endtask

	// pool of three tags in every set
	function automatic cache_pkg::proc_addr_t pool_addr();
		return make_addr($urandom % 3, $urandom % 4, $urandom % 4);
	endfunction

	task automatic d_random();
		int               waits;
		cache_pkg::word_t rdata;
		repeat (N_RANDOM) begin
			d_access($urandom % 2, pool_addr(), $urandom, waits, rdata);
		end
	endtask

	task automatic i_random();
		int waits;
		repeat (N_RANDOM) begin
			i_read(pool_addr(), waits);
		end
	endtask

	// ----------------------------------------------------------------------
	// main sequence
	// ----------------------------------------------------------------------
	initial begin
		int               waits;
		int               seen;
		cache_pkg::word_t rdata;
		void'($urandom(SEED));
		proc_reset   = 1'b1;
		d_proc_read  = 1'b0;
		d_proc_write = 1'b0;
		d_proc_addr  = '0;
		d_proc_wdata = '0;
		i_proc_read  = 1'b0;
		i_proc_addr  = '0;
		repeat (5) @(posedge clk);
		#2;
		proc_reset = 1'b0;
		@(negedge clk);
		if (d_proc_stall || d_mem_read || d_mem_write || i_proc_stall || i_mem_read) begin
			flag_error("stall or memory request high after reset");
		end
		@(posedge clk);
		#2;

		// instruction miss then a hit in the same line
		i_read(make_addr(0, 0, 2), waits);
		if (waits == 0) flag_error("instruction read of a cold line did not stall");
		seen = i_mem_cycles;
		i_read(make_addr(0, 0, 3), waits);
		if (waits != 0 || i_mem_cycles != seen) begin
			flag_error("instruction read of a filled line was not a zero-wait hit");
		end

		// write hit then read back with the neighbours untouched
		d_access(1'b0, make_addr(0, 1, 3), '0, waits, rdata);
		d_access(1'b1, make_addr(0, 1, 1), 32'hdead_beef, waits, rdata);
		if (waits != 0) flag_error("write to a cached line stalled");
		d_access(1'b0, make_addr(0, 1, 1), '0, waits, rdata);
		check_word("d_proc_rdata", rdata, 32'hdead_beef);
		if (waits != 0) flag_error("read after write to a cached line stalled");
		d_access(1'b0, make_addr(0, 1, 0), '0, waits, rdata);
		d_access(1'b0, make_addr(0, 1, 2), '0, waits, rdata);

		// third tag evicts the dirty line
		d_access(1'b0, make_addr(1, 1, 0), '0, waits, rdata);
		seen = wb_count;
		d_access(1'b0, make_addr(2, 1, 0), '0, waits, rdata);
		if (wb_count != seen + 1) flag_error("dirty victim was not written back");
		check_mem_addr("d_mem_addr", last_wb_addr, line_of(make_addr(0, 1, 0)));
		d_access(1'b0, make_addr(0, 1, 1), '0, waits, rdata);
		check_word("d_proc_rdata", rdata, 32'hdead_beef);

		// fill order in set 2 with A and B filled before C replaces A
		d_access(1'b0, make_addr(0, 2, 0), '0, waits, rdata);
		d_access(1'b0, make_addr(1, 2, 0), '0, waits, rdata);
		d_access(1'b0, make_addr(2, 2, 0), '0, waits, rdata);
		seen = d_mem_cycles;
		d_access(1'b0, make_addr(1, 2, 3), '0, waits, rdata);
		if (waits != 0 || d_mem_cycles != seen) flag_error("second filled line was evicted");
		d_access(1'b0, make_addr(0, 2, 0), '0, waits, rdata);
		if (waits == 0) flag_error("oldest line was not the one replaced");

		fork
			d_random();
			i_random();
		join

		repeat (2) @(posedge clk);
		$display("errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: verification/slow_mem.sv
// behavioral line memory that answers a held request after a fixed latency
`timescale 1ns/100ps

module slow_mem #(
	parameter int               mem_latency = 3,
	parameter int               n_lines     = 64,
	parameter cache_pkg::word_t pattern     = '0
) (
	input  logic                 clk,
	input  logic                 proc_reset,
	input  logic                 mem_read,
	input  logic                 mem_write,
	input  cache_pkg::mem_addr_t mem_addr,
	input  cache_pkg::line_t     mem_wdata,
	output cache_pkg::line_t     mem_rdata,
	output logic                 mem_ready
);

	cache_pkg::line_t                lines [n_lines];
	logic [cache_pkg::MEM_ADDR_W-1:0] line_addr;
	int                              count;

	assign line_addr = mem_addr;

	// every word starts as its own word address xor the pattern
	function automatic cache_pkg::word_t init_word(input int unsigned word_addr);
		return cache_pkg::word_t'(word_addr) ^ pattern;
	endfunction

	initial begin
		mem_rdata = '0;
		mem_ready = 1'b0;
		count     = 0;
		for (int l = 0; l < n_lines; l++) begin
			for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
				lines[l][w*cache_pkg::WORD_W +: cache_pkg::WORD_W] =
					init_word(l * cache_pkg::WORDS_PER_LINE + w);
			end
		end
	end

	// ----------------------------------------------------------------------
	// request timing
	// ----------------------------------------------------------------------
	always @(posedge clk) begin
		if (proc_reset) begin
			count     <= 0;
			mem_ready <= 1'b0;
		end else begin
			mem_ready <= 1'b0;                      // one-cycle pulse
			if ((mem_read || mem_write) && !mem_ready) begin
				if (count == mem_latency - 1) begin
					count     <= 0;
					mem_ready <= 1'b1;
					if (mem_read) begin
						mem_rdata <= lines[line_addr % n_lines];   // data comes with ready
					end
					if (mem_write) begin
						lines[line_addr % n_lines] <= mem_wdata;
					end
				end else begin
					count <= count + 1;
				end
			end
		end
	end

endmodule
